// ==== logic/tcb_pkg.sv ====
//////////////////////////////
// tcb bus format
//////////////////////////////

package tcb_pkg;

  // address width in bits, byte addressed
  localparam int ADR_W = 16;
  // data width, one word per transfer
  localparam int DAT_W = 32;
  // one enable per data byte
  localparam int BEN_W = DAT_W / 8;

  // byte address
  typedef logic [ADR_W-1:0] adr_t;
  // data word, read or write
  typedef logic [DAT_W-1:0] dat_t;
  // byte enables, bit n covers byte n
  typedef logic [BEN_W-1:0] ben_t;

  //////////////////////////////
  // timing
  //////////////////////////////

  // cycles from request to response at a subordinate port
  // every subordinate here registers its response once
  localparam int SUB_DLY = 1;

endpackage

// ==== logic/sys_pkg.sv ====
//////////////////////////////
// system memory map
//////////////////////////////

package sys_pkg;

  // sram region, 4 KiB at the bottom
  localparam tcb_pkg::adr_t MEM_BASE = 16'h0000;
  localparam tcb_pkg::adr_t MEM_MASK = 16'h0FFF;

  // register block, 16 bytes
  localparam tcb_pkg::adr_t REG_BASE = 16'h1000;
  localparam tcb_pkg::adr_t REG_MASK = 16'h000F;

  //////////////////////////////
  // register offsets
  //////////////////////////////

  // byte offsets inside the register region
  localparam tcb_pkg::adr_t REG_SCRATCH = 16'h0000;
  localparam tcb_pkg::adr_t REG_WCOUNT  = 16'h0004;
  localparam tcb_pkg::adr_t REG_ID      = 16'h0008;

  // read-only identifier
  localparam tcb_pkg::dat_t ID_VALUE = 32'h7CB5_0102;

endpackage

// ==== logic/tcb_register_slice.sv ====
`timescale 1ns/1ns

module tcb_register_slice #(
  // register the request path
  parameter bit CFG_REQ_REG = 1'b1,
  // register the response path
  parameter bit CFG_RSP_REG = 1'b1,
  // response delay seen on the upstream side
  parameter int DLY = 3
) (
  input  logic          sub,
  input  logic          arst_n,
  // upstream, manager connects here
  input  logic          sub_vld,
  input  logic          sub_wen,
  input  tcb_pkg::adr_t sub_adr,
  input  tcb_pkg::ben_t sub_ben,
  input  tcb_pkg::dat_t sub_wdt,
  output tcb_pkg::dat_t sub_rdt,
  output logic          sub_err,
  // downstream, toward the subordinates
  output logic          man_vld,
  output logic          man_wen,
  output tcb_pkg::adr_t man_adr,
  output tcb_pkg::ben_t man_ben,
  output tcb_pkg::dat_t man_wdt,
  input  tcb_pkg::dat_t man_rdt,
  input  logic          man_err
);

  import tcb_pkg::*;

  //////////////////////////////
  // parameter check
  //////////////////////////////

  // upstream delay is downstream delay plus our own stages
  if (DLY != SUB_DLY + int'(CFG_REQ_REG) + int'(CFG_RSP_REG)) begin : gen_dly_chk
    $error("%m: DLY = %0d, expected %0d", DLY,
           SUB_DLY + int'(CFG_REQ_REG) + int'(CFG_RSP_REG));
  end

  //////////////////////////////
  // request
  //////////////////////////////

  if (CFG_REQ_REG) begin : gen_req_reg
    // valid is control, cleared on reset
    always_ff @(posedge sub or negedge arst_n) begin
      if (!arst_n) begin
        man_vld <= 1'b0;
      end else begin
        man_vld <= sub_vld;
      end
    end

    // payload follows along, no reset
    always_ff @(posedge sub) begin
      man_wen <= sub_wen;
      man_adr <= sub_adr;
      man_ben <= sub_ben;
      man_wdt <= sub_wdt;
    end

    // one cycle shift of the transfer stream
    a_vld_follow : assert property (
      @(posedge sub) disable iff (!arst_n)
      1'b1 |=> (man_vld == $past(sub_vld))
    ) else $error("%m: man_vld lost track of sub_vld");
  end else begin : gen_req_cmb
    assign man_vld = sub_vld;
    assign man_wen = sub_wen;
    assign man_adr = sub_adr;
    assign man_ben = sub_ben;
    assign man_wdt = sub_wdt;
  end

  //////////////////////////////
  // response
  //////////////////////////////

  if (CFG_RSP_REG) begin : gen_rsp_reg
    // response data and error, one stage
    always_ff @(posedge sub) begin
      sub_rdt <= man_rdt;
      sub_err <= man_err;
    end
  end else begin : gen_rsp_cmb
    assign sub_rdt = man_rdt;
    assign sub_err = man_err;
  end

endmodule

// ==== logic/tcb_decoder.sv ====
`timescale 1ns/1ns

module tcb_decoder (
  input  logic          sub,
  input  logic          arst_n,
  // upstream, from the register slice
  input  logic          man_vld,
  input  logic          man_wen,
  input  tcb_pkg::adr_t man_adr,
  input  tcb_pkg::ben_t man_ben,
  input  tcb_pkg::dat_t man_wdt,
  output tcb_pkg::dat_t man_rdt,
  output logic          man_err,
  // sram side
  output logic          mem_vld,
  output logic          mem_wen,
  output tcb_pkg::adr_t mem_adr,
  output tcb_pkg::ben_t mem_ben,
  output tcb_pkg::dat_t mem_wdt,
  input  tcb_pkg::dat_t mem_rdt,
  // register block side
  output logic          reg_vld,
  output logic          reg_wen,
  output tcb_pkg::adr_t reg_adr,
  output tcb_pkg::ben_t reg_ben,
  output tcb_pkg::dat_t reg_wdt,
  input  tcb_pkg::dat_t reg_rdt,
  input  logic          reg_err
);

  import tcb_pkg::*;
  import sys_pkg::*;

  // region hits on the incoming address
  logic hit_mem;
  logic hit_reg;
  // transfer that matches no region
  logic unm;

  // select history with stage 0 newest
  logic [SUB_DLY-1:0] mem_sel_q;
  logic [SUB_DLY-1:0] reg_sel_q;
  logic [SUB_DLY-1:0] unm_q;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // base compare above the region mask
  assign hit_mem = (man_adr & ~MEM_MASK) == MEM_BASE;
  assign hit_reg = (man_adr & ~REG_MASK) == REG_BASE;
  assign unm     = man_vld & ~hit_mem & ~hit_reg;

  // at most one valid goes out
  assign mem_vld = man_vld & hit_mem;
  assign reg_vld = man_vld & hit_reg;

  // payload broadcast with the address made region relative
  assign mem_wen = man_wen;
  assign mem_adr = man_adr & MEM_MASK;
  assign mem_ben = man_ben;
  assign mem_wdt = man_wdt;

  assign reg_wen = man_wen;
  assign reg_adr = man_adr & REG_MASK;
  assign reg_ben = man_ben;
  assign reg_wdt = man_wdt;

  //////////////////////////////
  // response select
  //////////////////////////////

  // select flags travel as long as a subordinate takes
  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      mem_sel_q <= '0;
      reg_sel_q <= '0;
      unm_q     <= '0;
    end else begin
      mem_sel_q[0] <= mem_vld;
      reg_sel_q[0] <= reg_vld;
      unm_q[0]     <= unm;
      for (int i = 1; i < SUB_DLY; i++) begin
        mem_sel_q[i] <= mem_sel_q[i-1];
        reg_sel_q[i] <= reg_sel_q[i-1];
        unm_q[i]     <= unm_q[i-1];
      end
    end
  end

  // oldest stage lines up with the subordinate response
  always_comb begin
    man_rdt = '0;
    man_err = 1'b0;
    if (unm_q[SUB_DLY-1]) begin
      // unmapped gives zero data and error
      man_err = 1'b1;
    end else if (mem_sel_q[SUB_DLY-1]) begin
      man_rdt = mem_rdt;
    end else if (reg_sel_q[SUB_DLY-1]) begin
      man_rdt = reg_rdt;
      man_err = reg_err;
    end
  end

  // regions in the memory map must not overlap
  a_one_hot_vld : assert property (
    @(posedge sub) disable iff (!arst_n)
    !(mem_vld && reg_vld)
  ) else $error("%m: both subordinates selected");

endmodule

// ==== logic/tcb_memory.sv ====
`timescale 1ns/1ns

module tcb_memory #(
  // number of data words
  parameter int DEPTH = 1024
) (
  input  logic          sub,
  input  logic          arst_n,
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  output tcb_pkg::dat_t rdt
);

  import tcb_pkg::*;

  // word index width
  localparam int IDX_W = $clog2(DEPTH);

  // storage, no reset
  dat_t mem_q [DEPTH];

  // word address, byte lanes dropped
  logic [IDX_W-1:0] idx;

  assign idx = adr[IDX_W+1:2];

  //////////////////////////////
  // write port
  //////////////////////////////

  // only enabled byte lanes change
  always_ff @(posedge sub) begin
    if (vld && wen) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (ben[b]) begin
          mem_q[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read, data one cycle later
  always_ff @(posedge sub) begin
    if (vld && !wen) begin
      rdt <= mem_q[idx];
    end
  end

  // a write with no lanes enabled is a manager bug
  a_wr_ben : assert property (
    @(posedge sub) disable iff (!arst_n)
    (vld && wen) |-> (ben != '0)
  ) else $error("%m: write with empty byte enables");

endmodule

// ==== logic/tcb_regs.sv ====
`timescale 1ns/1ns

module tcb_regs (
  input  logic          sub,
  input  logic          arst_n,
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  import tcb_pkg::*;
  import sys_pkg::*;

  // register contents
  dat_t scratch_q;
  dat_t wcount_q;

  // offset decode
  logic sel_scratch;
  logic sel_wcount;
  logic sel_id;
  // access that must be refused
  logic bad;
  // write that goes through
  logic wr_ok;
  // read mux
  dat_t rd_mux;

  //////////////////////////////
  // decode
  //////////////////////////////

  assign sel_scratch = adr == REG_SCRATCH;
  assign sel_wcount  = adr == REG_WCOUNT;
  assign sel_id      = adr == REG_ID;

  // undefined offset, or a write to the id
  assign bad   = vld & ((~sel_scratch & ~sel_wcount & ~sel_id) | (sel_id & wen));
  assign wr_ok = vld & wen & ~bad;

  always_comb begin
    rd_mux = '0;
    if (sel_scratch) rd_mux = scratch_q;
    if (sel_wcount)  rd_mux = wcount_q;
    if (sel_id)      rd_mux = ID_VALUE;
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge sub or negedge arst_n) begin
    if (!arst_n) begin
      scratch_q <= '0;
      wcount_q  <= '0;
      err       <= 1'b0;
    end else begin
      // scratch, byte writable
      if (wr_ok && sel_scratch) begin
        for (int b = 0; b < BEN_W; b++) begin
          if (ben[b]) scratch_q[8*b +: 8] <= wdt[8*b +: 8];
        end
      end
      // counts every accepted write, wraps at 2^32
      if (wr_ok) begin
        wcount_q <= wcount_q + 1'b1;
      end
      err <= bad;
    end
  end

  // read data, one cycle late like the sram
  always_ff @(posedge sub) begin
    if (vld && !wen) begin
      rdt <= rd_mux;
    end
  end

endmodule

// ==== logic/tcb_subsystem.sv ====
`timescale 1ns/1ns

module tcb_subsystem #(
  // slice configuration, passed down
  parameter bit CFG_REQ_REG = 1'b1,
  parameter bit CFG_RSP_REG = 1'b1
) (
  input  logic          sub,
  input  logic          arst_n,
  // manager request
  input  logic          sub_vld,
  input  logic          sub_wen,
  input  tcb_pkg::adr_t sub_adr,
  input  tcb_pkg::ben_t sub_ben,
  input  tcb_pkg::dat_t sub_wdt,
  // response, DLY cycles later
  output tcb_pkg::dat_t sub_rdt,
  output logic          sub_err
);

  import tcb_pkg::*;
  import sys_pkg::*;

  // delay seen at the top ports
  localparam int DLY = SUB_DLY + int'(CFG_REQ_REG) + int'(CFG_RSP_REG);
  // sram words covered by the region
  localparam int MEM_DEPTH = (int'(MEM_MASK) + 1) / (DAT_W / 8);

  //////////////////////////////
  // internal buses
  //////////////////////////////

  // slice to decoder
  logic man_vld;
  logic man_wen;
  adr_t man_adr;
  ben_t man_ben;
  dat_t man_wdt;
  dat_t man_rdt;
  logic man_err;

  // decoder to sram
  logic mem_vld;
  logic mem_wen;
  adr_t mem_adr;
  ben_t mem_ben;
  dat_t mem_wdt;
  dat_t mem_rdt;

  // decoder to register block
  logic reg_vld;
  logic reg_wen;
  adr_t reg_adr;
  ben_t reg_ben;
  dat_t reg_wdt;
  dat_t reg_rdt;
  logic reg_err;

  tcb_register_slice #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG),
    .DLY         (DLY)
  ) u_slice (
    .sub     (sub),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_wen (sub_wen),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdt (sub_rdt),
    .sub_err (sub_err),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdt (man_rdt),
    .man_err (man_err)
  );

  tcb_decoder u_decoder (
    .sub     (sub),
    .arst_n  (arst_n),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdt (man_rdt),
    .man_err (man_err),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt),
    .reg_vld (reg_vld),
    .reg_wen (reg_wen),
    .reg_adr (reg_adr),
    .reg_ben (reg_ben),
    .reg_wdt (reg_wdt),
    .reg_rdt (reg_rdt),
    .reg_err (reg_err)
  );

  tcb_memory #(
    .DEPTH (MEM_DEPTH)
  ) u_memory (
    .sub    (sub),
    .arst_n (arst_n),
    .vld    (mem_vld),
    .wen    (mem_wen),
    .adr    (mem_adr),
    .ben    (mem_ben),
    .wdt    (mem_wdt),
    .rdt    (mem_rdt)
  );

  tcb_regs u_regs (
    .sub    (sub),
    .arst_n (arst_n),
    .vld    (reg_vld),
    .wen    (reg_wen),
    .adr    (reg_adr),
    .ben    (reg_ben),
    .wdt    (reg_wdt),
    .rdt    (reg_rdt),
    .err    (reg_err)
  );

endmodule

// ==== tb/tcb_subsystem_tb.sv ====
`timescale 1ns/1ns

module tcb_subsystem_tb;

  import tcb_pkg::*;
  import sys_pkg::*;

  // slice config, both paths registered
  localparam bit CFG_REQ_REG = 1'b1;
  localparam bit CFG_RSP_REG = 1'b1;
  // one subordinate stage plus the slice stages
  localparam int DLY = 1 + int'(CFG_REQ_REG) + int'(CFG_RSP_REG);

  localparam int RST_CYC = 5;
  // sram window for the random phase, clear of the table addresses
  localparam adr_t RND_BASE  = 16'h0400;
  localparam int   RND_WORDS = 16;
  localparam int   RND_CNT   = 200;

  logic sub;
  logic arst_n;
  logic sub_vld;
  logic sub_wen;
  adr_t sub_adr;
  ben_t sub_ben;
  dat_t sub_wdt;
  dat_t sub_rdt;
  logic sub_err;

  // rising edge count
  int cyc = 0;
  int n_checked = 0;

  // stimulus table, one entry per transfer
  string tbl_name [$];
  logic  tbl_wen  [$];
  adr_t  tbl_adr  [$];
  ben_t  tbl_ben  [$];
  dat_t  tbl_wdt  [$];
  dat_t  tbl_rdt  [$];
  logic  tbl_err  [$];

  // responses still to come, oldest first
  int    exp_due  [$];
  string exp_name [$];
  logic  exp_read [$];
  dat_t  exp_rdt  [$];
  logic  exp_err  [$];

  // byte model of the random window
  logic [7:0] mdl [RND_WORDS*4];

  tcb_subsystem #(
    .CFG_REQ_REG (CFG_REQ_REG),
    .CFG_RSP_REG (CFG_RSP_REG)
  ) DUT (
    .sub     (sub),
    .arst_n  (arst_n),
    .sub_vld (sub_vld),
    .sub_wen (sub_wen),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdt (sub_rdt),
    .sub_err (sub_err)
  );

  initial sub = 1'b0;
  always #5 sub = ~sub;

  always @(posedge sub) cyc <= cyc + 1;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_value(input string name, input dat_t exp, input dat_t act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "response did not match");
    end
  endtask

  task automatic add_step(input string name, input logic wen, input adr_t adr,
                          input ben_t ben, input dat_t wdt, input dat_t rdt, input logic err);
    tbl_name.push_back(name);
    tbl_wen.push_back(wen);
    tbl_adr.push_back(adr);
    tbl_ben.push_back(ben);
    tbl_wdt.push_back(wdt);
    tbl_rdt.push_back(rdt);
    tbl_err.push_back(err);
  endtask

  // one transfer, response due DLY edges after the DUT takes it
  task automatic issue(input string name, input logic wen, input adr_t adr,
                       input ben_t ben, input dat_t wdt, input dat_t rdt, input logic err);
    @(posedge sub);
    #1;
    sub_vld = 1'b1;
    sub_wen = wen;
    sub_adr = adr;
    sub_ben = ben;
    sub_wdt = wdt;
    exp_due.push_back(cyc + DLY);
    exp_name.push_back(name);
    exp_read.push_back(!wen);
    exp_rdt.push_back(rdt);
    exp_err.push_back(err);
  endtask

  task automatic idle();
    @(posedge sub);
    #1;
    sub_vld = 1'b0;
    sub_wen = 1'b0;
  endtask

  task automatic model_write(input int idx, input ben_t ben, input dat_t wdt);
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) mdl[4*idx+b] = wdt[8*b +: 8];
    end
  endtask

  function automatic dat_t model_read(input int idx);
    return {mdl[4*idx+3], mdl[4*idx+2], mdl[4*idx+1], mdl[4*idx]};
  endfunction

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic load_table();
    // full word then read back
    add_step("mem_wr_full",   1'b1, 16'h0000, 4'hF, 32'hDEAD_BEEF, '0, 1'b0);
    add_step("mem_rd_full",   1'b0, 16'h0000, 4'hF, '0, 32'hDEAD_BEEF, 1'b0);
    // lanes 0 and 2 replaced
    add_step("mem_wr_base",   1'b1, 16'h0004, 4'hF, 32'h1122_3344, '0, 1'b0);
    add_step("mem_wr_part",   1'b1, 16'h0004, 4'b0101, 32'hAABB_CCDD, '0, 1'b0);
    add_step("mem_rd_part",   1'b0, 16'h0004, 4'hF, '0, 32'h11BB_33DD, 1'b0);
    // top word, mixed with register traffic
    add_step("mem_wr_top",    1'b1, 16'h0FFC, 4'hF, 32'h0F0F_A5A5, '0, 1'b0);
    add_step("reg_wr_scr",    1'b1, 16'h1000, 4'hF, 32'h1234_5678, '0, 1'b0);
    add_step("mem_rd_top",    1'b0, 16'h0FFC, 4'hF, '0, 32'h0F0F_A5A5, 1'b0);
    add_step("reg_rd_scr",    1'b0, 16'h1000, 4'hF, '0, 32'h1234_5678, 1'b0);
    add_step("reg_wr_scr_b3", 1'b1, 16'h1000, 4'b1000, 32'h9A00_0000, '0, 1'b0);
    add_step("reg_rd_scr_b3", 1'b0, 16'h1000, 4'hF, '0, 32'h9A34_5678, 1'b0);
    add_step("reg_rd_id",     1'b0, 16'h1008, 4'hF, '0, ID_VALUE, 1'b0);
    // two scratch writes so far
    add_step("reg_rd_wcnt",   1'b0, 16'h1004, 4'hF, '0, 32'd2, 1'b0);
    // refused accesses
    add_step("reg_wr_id",     1'b1, 16'h1008, 4'hF, 32'hFFFF_FFFF, '0, 1'b1);
    add_step("reg_rd_undef",  1'b0, 16'h100C, 4'hF, '0, '0, 1'b1);
    add_step("reg_wr_undef",  1'b1, 16'h100C, 4'hF, 32'h5555_5555, '0, 1'b1);
    add_step("unmap_rd",      1'b0, 16'h2000, 4'hF, '0, '0, 1'b1);
    add_step("unmap_wr",      1'b1, 16'h8000, 4'hF, 32'h0BAD_0BAD, '0, 1'b1);
    // nothing moved after the errors
    add_step("reg_rd_id_2",   1'b0, 16'h1008, 4'hF, '0, ID_VALUE, 1'b0);
    add_step("reg_rd_scr_2",  1'b0, 16'h1000, 4'hF, '0, 32'h9A34_5678, 1'b0);
    add_step("reg_rd_wcnt_2", 1'b0, 16'h1004, 4'hF, '0, 32'd2, 1'b0);
    add_step("mem_rd_full_2", 1'b0, 16'h0000, 4'hF, '0, 32'hDEAD_BEEF, 1'b0);
  endtask

  //////////////////////////////
  // random sram traffic
  //////////////////////////////

  task automatic run_random();
    int   idx;
    logic wen;
    ben_t ben;
    dat_t wdt;
    adr_t adr;
    // fill the window so every byte is known
    for (int k = 0; k < RND_WORDS; k++) begin
      wdt = $urandom;
      adr = adr_t'(RND_BASE + 4*k);
      model_write(k, 4'hF, wdt);
      issue($sformatf("rnd_fill_%0d", k), 1'b1, adr, 4'hF, wdt, '0, 1'b0);
    end
    for (int k = 0; k < RND_CNT; k++) begin
      idx = int'($urandom_range(RND_WORDS-1, 0));
      wen = ($urandom_range(1, 0) == 1);
      adr = adr_t'(RND_BASE + 4*idx);
      if (wen) begin
        // never an empty lane set
        ben = ben_t'($urandom_range(15, 1));
        wdt = $urandom;
        model_write(idx, ben, wdt);
        issue($sformatf("rnd_wr_%0d", k), 1'b1, adr, ben, wdt, '0, 1'b0);
      end else begin
        issue($sformatf("rnd_rd_%0d", k), 1'b0, adr, 4'hF, '0, model_read(idx), 1'b0);
      end
    end
  endtask

  //////////////////////////////
  // response monitor
  //////////////////////////////

  // mid cycle, outputs settled
  always @(negedge sub) begin
    if (exp_due.size() != 0 && exp_due[0] == cyc) begin
      if (exp_read[0]) begin
        check_value($sformatf("%s rdt", exp_name[0]), exp_rdt[0], sub_rdt);
      end
      check_value($sformatf("%s err", exp_name[0]), dat_t'(exp_err[0]), dat_t'(sub_err));
      void'(exp_due.pop_front());
      void'(exp_name.pop_front());
      void'(exp_read.pop_front());
      void'(exp_rdt.pop_front());
      void'(exp_err.pop_front());
      n_checked++;
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hccc6));
    arst_n  = 1'b0;
    sub_vld = 1'b0;
    sub_wen = 1'b0;
    sub_adr = '0;
    sub_ben = '0;
    sub_wdt = '0;
    load_table();
    repeat (RST_CYC) @(posedge sub);
    #1 arst_n = 1'b1;
    // table back to back
    for (int i = 0; i < tbl_name.size(); i++) begin
      issue(tbl_name[i], tbl_wen[i], tbl_adr[i], tbl_ben[i], tbl_wdt[i], tbl_rdt[i], tbl_err[i]);
    end
    run_random();
    idle();
    // drain the pipeline
    repeat (DLY + 2) @(posedge sub);
    if (exp_due.size() != 0) begin
      $display("%0d responses never arrived", exp_due.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "responses missing at end of run");
    end else begin
      $display("%0d responses checked", n_checked);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // bound on the whole run
  initial begin
    int wd_ns;
    @(posedge arst_n);
    wd_ns = (tbl_name.size() + RND_WORDS + RND_CNT + 20) * 10;
    #(wd_ns);
    $display("watchdog expired after %0d ns, the run did not finish", wd_ns);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

// ==== flist.f ====
logic/tcb_pkg.sv
logic/sys_pkg.sv
logic/tcb_register_slice.sv
logic/tcb_decoder.sv
logic/tcb_memory.sv
logic/tcb_regs.sv
logic/tcb_subsystem.sv
tb/tcb_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the tcb subsystem testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f flist.f \
  --top-module tcb_subsystem_tb \
  --Mdir obj_dir \
  -o tcb_sim

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/tcb_sim
